/* build.f */
+incdir+source
source/mips_pkg.sv
source/bypass_if.sv
source/fetch_stage.sv
source/decode_stage.sv
source/reg_file.sv
source/execute_stage.sv
source/mem_wb_stage.sv
source/core.sv
tests/core_tb.sv

/* run.sh */
#!/bin/sh
# Build the core testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module core_tb -f build.f -o core_tb_sim
output=$(./obj_dir/core_tb_sim)
echo "$output"

if echo "$output" | grep -q "^STATUS: PASS$"; then
  exit 0
fi
exit 1

/* source/bypass_if.sv */
`default_nettype none

// Pending register write of one pipeline stage
interface bypass_if;
  import mips_pkg::*;

  logic      reg_write;
  reg_addr_t dest;
  data_t     value;
  logic      is_load;

  modport source (output reg_write, dest, value, is_load);
  modport sink   (input reg_write, dest, value, is_load);

endinterface

`default_nettype wire

/* source/core.sv */
`default_nettype none

module core (
  input  wire logic                clk,
  input  wire logic                arst_n_i,
  input  wire logic                stall_i,
  // ROM
  output mips_pkg::addr_t          rom_addr_o,
  input  wire mips_pkg::data_t     rom_data_i,
  // RAM
  output logic                     ram_en_o,
  output logic                     ram_write_en_o,
  output mips_pkg::addr_t          ram_addr_o,
  output mips_pkg::data_t          ram_write_data_o,
  input  wire mips_pkg::data_t     ram_read_data_i,
  // Write-back trace
  output logic                     debug_reg_write_en_o,
  output mips_pkg::reg_addr_t      debug_reg_write_addr_o,
  output mips_pkg::data_t          debug_reg_write_data_o,
  output mips_pkg::addr_t          debug_pc_o
);
  import mips_pkg::*;

  addr_t     if_pc;
  inst_u     if_inst;
  logic      hold;
  logic      branch_taken;
  addr_t     branch_target;
  reg_addr_t rs_addr;
  reg_addr_t rt_addr;
  data_t     rs_data;
  data_t     rt_data;
  idex_t     idex;
  exmem_t    exmem;

  bypass_if ex_bypass ();
  bypass_if mem_bypass ();

  fetch_stage fetch_inst (
    .clk             (clk),
    .arst_n_i        (arst_n_i),
    .stall_i         (stall_i),
    .hold_i          (hold),
    .branch_taken_i  (branch_taken),
    .branch_target_i (branch_target),
    .rom_data_i      (rom_data_i),
    .rom_addr_o      (rom_addr_o),
    .pc_o            (if_pc),
    .inst_o          (if_inst)
  );

  decode_stage decode_inst (
    .clk             (clk),
    .arst_n_i        (arst_n_i),
    .stall_i         (stall_i),
    .pc_i            (if_pc),
    .inst_i          (if_inst),
    .rs_data_i       (rs_data),
    .rt_data_i       (rt_data),
    .ex_bypass       (ex_bypass.sink),
    .mem_bypass      (mem_bypass.sink),
    .rs_addr_o       (rs_addr),
    .rt_addr_o       (rt_addr),
    .hold_o          (hold),
    .branch_taken_o  (branch_taken),
    .branch_target_o (branch_target),
    .idex_o          (idex)
  );

  reg_file reg_file_inst (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .rs_addr_i    (rs_addr),
    .rt_addr_i    (rt_addr),
    .rs_data_o    (rs_data),
    .rt_data_o    (rt_data),
    .write_en_i   (debug_reg_write_en_o),
    .write_addr_i (debug_reg_write_addr_o),
    .write_data_i (debug_reg_write_data_o)
  );

  execute_stage execute_inst (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .stall_i   (stall_i),
    .idex_i    (idex),
    .exmem_o   (exmem),
    .ex_bypass (ex_bypass.source)
  );

  mem_wb_stage mem_wb_inst (
    .clk              (clk),
    .arst_n_i         (arst_n_i),
    .stall_i          (stall_i),
    .exmem_i          (exmem),
    .ram_en_o         (ram_en_o),
    .ram_write_en_o   (ram_write_en_o),
    .ram_addr_o       (ram_addr_o),
    .ram_write_data_o (ram_write_data_o),
    .ram_read_data_i  (ram_read_data_i),
    .wb_en_o          (debug_reg_write_en_o),
    .wb_addr_o        (debug_reg_write_addr_o),
    .wb_data_o        (debug_reg_write_data_o),
    .wb_pc_o          (debug_pc_o),
    .mem_bypass       (mem_bypass.source)
  );

endmodule

`default_nettype wire

/* source/core_macros.svh */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Datapath widths
`define DATA_W      32
`define ADDR_W      32
`define REG_ADDR_W  5
`define REG_COUNT   32

// Instruction field widths
`define OPCODE_W    6
`define FUNCT_W     6
`define SHAMT_W     5
`define IMM_W       16

`define RESET_PC    32'h0000_0000

// Primary opcodes
`define OP_SPECIAL  6'b000000
`define OP_BEQ      6'b000100
`define OP_BNE      6'b000101
`define OP_ADDIU    6'b001001
`define OP_ORI      6'b001101
`define OP_LUI      6'b001111
`define OP_LW       6'b100011
`define OP_SW       6'b101011

// SPECIAL funct codes
`define FN_SLL      6'b000000
`define FN_ADDU     6'b100001
`define FN_SUBU     6'b100011
`define FN_AND      6'b100100
`define FN_OR       6'b100101
`define FN_SLT      6'b101010

`endif

/* source/decode_stage.sv */
`default_nettype none

`include "core_macros.svh"

module decode_stage (
  input  wire logic            clk,
  input  wire logic            arst_n_i,
  input  wire logic            stall_i,
  input  wire mips_pkg::addr_t pc_i,
  input  wire mips_pkg::inst_u inst_i,
  input  wire mips_pkg::data_t rs_data_i,
  input  wire mips_pkg::data_t rt_data_i,
  bypass_if.sink               ex_bypass,
  bypass_if.sink               mem_bypass,
  output mips_pkg::reg_addr_t  rs_addr_o,
  output mips_pkg::reg_addr_t  rt_addr_o,
  output logic                 hold_o,
  output logic                 branch_taken_o,
  output mips_pkg::addr_t      branch_target_o,
  output mips_pkg::idex_t      idex_o
);
  import mips_pkg::*;

  logic  use_rs;
  logic  use_rt;
  logic  is_branch;
  logic  branch_eq;
  data_t rs_val;
  data_t rt_val;
  data_t imm_sext;
  idex_t id_word;

  // EX result wins over MEM, register file last
  function automatic data_t forward(input reg_addr_t addr, input data_t rf_val);
    if (addr != '0 && ex_bypass.reg_write && ex_bypass.dest == addr) begin
      return ex_bypass.value;
    end else if (addr != '0 && mem_bypass.reg_write && mem_bypass.dest == addr) begin
      return mem_bypass.value;
    end
    return rf_val;
  endfunction

  function automatic logic load_pending(input reg_addr_t addr);
    logic ex_hit;
    logic mem_hit;
    ex_hit  = ex_bypass.reg_write && ex_bypass.dest == addr;
    mem_hit = mem_bypass.reg_write && mem_bypass.dest == addr;
    return (addr != '0) && (ex_hit ? ex_bypass.is_load : (mem_hit && mem_bypass.is_load));
  endfunction

  assign rs_addr_o = inst_i.r.rs;
  assign rt_addr_o = inst_i.r.rt;
  assign imm_sext  = {{(`DATA_W-`IMM_W){inst_i.i.imm16[`IMM_W-1]}}, inst_i.i.imm16};
  assign branch_target_o = pc_i + addr_t'(4) + addr_t'({imm_sext[`DATA_W-3:0], 2'b00});

  always_comb begin
    rs_val = forward(inst_i.r.rs, rs_data_i);
    rt_val = forward(inst_i.r.rt, rt_data_i);
  end

  always_comb begin
    id_word            = '0;
    id_word.valid      = 1'b1;
    id_word.alu_op     = ALU_ADD;
    id_word.operand_a  = rs_val;
    id_word.operand_b  = rt_val;
    id_word.shamt      = inst_i.r.shamt;
    id_word.store_data = rt_val;
    id_word.dest       = inst_i.r.rd;
    id_word.pc         = pc_i;
    use_rs    = 1'b1;
    use_rt    = 1'b0;
    is_branch = 1'b0;
    branch_eq = 1'b0;
    case (inst_i.r.opcode)
      `OP_SPECIAL: begin
        use_rt            = 1'b1;
        id_word.reg_write = 1'b1;
        case (inst_i.r.funct)
          `FN_ADDU: id_word.alu_op = ALU_ADD;
          `FN_SUBU: id_word.alu_op = ALU_SUB;
          `FN_AND:  id_word.alu_op = ALU_AND;
          `FN_OR:   id_word.alu_op = ALU_OR;
          `FN_SLT:  id_word.alu_op = ALU_SLT;
          `FN_SLL: begin
            id_word.alu_op = ALU_SLL;
            use_rs         = 1'b0;
          end
          default:  id_word.reg_write = 1'b0;
        endcase
      end
      `OP_ADDIU, `OP_LW: begin
        id_word.operand_b = imm_sext;
        id_word.dest      = inst_i.i.rt;
        id_word.reg_write = 1'b1;
        id_word.mem_read  = (inst_i.i.opcode == `OP_LW);
      end
      `OP_ORI: begin
        id_word.alu_op    = ALU_OR;
        id_word.operand_b = data_t'(inst_i.i.imm16);
        id_word.dest      = inst_i.i.rt;
        id_word.reg_write = 1'b1;
      end
      `OP_LUI: begin
        use_rs            = 1'b0;
        id_word.alu_op    = ALU_OR;
        id_word.operand_a = '0;
        id_word.operand_b = {inst_i.i.imm16, {`IMM_W{1'b0}}};
        id_word.dest      = inst_i.i.rt;
        id_word.reg_write = 1'b1;
      end
      `OP_SW: begin
        use_rt            = 1'b1;
        id_word.operand_b = imm_sext;
        id_word.mem_write = 1'b1;
      end
      `OP_BEQ, `OP_BNE: begin
        use_rt    = 1'b1;
        is_branch = 1'b1;
        branch_eq = (inst_i.i.opcode == `OP_BEQ);
      end
      default: use_rs = 1'b0;
    endcase
    // Register 0 writes die here
    if (id_word.dest == '0) begin
      id_word.reg_write = 1'b0;
    end
    hold_o = (use_rs && load_pending(inst_i.r.rs)) || (use_rt && load_pending(inst_i.r.rt));
    branch_taken_o = is_branch && (branch_eq ? (rs_val == rt_val) : (rs_val != rt_val));
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      idex_o <= '0;
    end else if (!stall_i) begin
      // Bubble while waiting on a load
      idex_o <= hold_o ? '0 : id_word;
    end
  end

endmodule

`default_nettype wire

/* source/execute_stage.sv */
`default_nettype none

module execute_stage (
  input  wire logic             clk,
  input  wire logic             arst_n_i,
  input  wire logic             stall_i,
  input  wire mips_pkg::idex_t  idex_i,
  output mips_pkg::exmem_t      exmem_o,
  bypass_if.source              ex_bypass
);
  import mips_pkg::*;

  data_t  result;
  exmem_t ex_word;

  always_comb begin
    case (idex_i.alu_op)
      ALU_ADD: result = idex_i.operand_a + idex_i.operand_b;
      ALU_SUB: result = idex_i.operand_a - idex_i.operand_b;
      ALU_AND: result = idex_i.operand_a & idex_i.operand_b;
      ALU_OR:  result = idex_i.operand_a | idex_i.operand_b;
      // signed compare
      ALU_SLT: result = data_t'($signed(idex_i.operand_a) < $signed(idex_i.operand_b));
      ALU_SLL: result = idex_i.operand_b << idex_i.shamt;
      default: result = '0;
    endcase
  end

  // Loads expose the address here, so decode must wait
  assign ex_bypass.reg_write = idex_i.valid && idex_i.reg_write;
  assign ex_bypass.dest      = idex_i.dest;
  assign ex_bypass.value     = result;
  assign ex_bypass.is_load   = idex_i.mem_read;

  assign ex_word = '{
    valid:      idex_i.valid,
    result:     result,
    mem_read:   idex_i.mem_read,
    mem_write:  idex_i.mem_write,
    store_data: idex_i.store_data,
    reg_write:  idex_i.reg_write,
    dest:       idex_i.dest,
    pc:         idex_i.pc
  };

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exmem_o <= '0;
    end else if (!stall_i) begin
      exmem_o <= ex_word;
    end
  end

endmodule

`default_nettype wire

/* source/fetch_stage.sv */
`default_nettype none

`include "core_macros.svh"

module fetch_stage (
  input  wire logic            clk,
  input  wire logic            arst_n_i,
  input  wire logic            stall_i,
  input  wire logic            hold_i,
  input  wire logic            branch_taken_i,
  input  wire mips_pkg::addr_t branch_target_i,
  input  wire mips_pkg::data_t rom_data_i,
  output mips_pkg::addr_t      rom_addr_o,
  output mips_pkg::addr_t      pc_o,
  output mips_pkg::inst_u      inst_o
);
  import mips_pkg::*;

  addr_t pc_q;

  assign rom_addr_o = pc_q;

  // IF/ID resets to an all-zero word, which decodes as a nop
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q   <= `RESET_PC;
      pc_o   <= `RESET_PC;
      inst_o <= '0;
    end else if (!stall_i && !hold_i) begin
      // Taken branch redirects after the delay slot fetch
      pc_q   <= branch_taken_i ? branch_target_i : pc_q + addr_t'(4);
      pc_o   <= pc_q;
      inst_o <= rom_data_i;
    end
  end

endmodule

`default_nettype wire

/* source/mem_wb_stage.sv */
`default_nettype none

module mem_wb_stage (
  input  wire logic                clk,
  input  wire logic                arst_n_i,
  input  wire logic                stall_i,
  input  wire mips_pkg::exmem_t    exmem_i,
  output logic                     ram_en_o,
  output logic                     ram_write_en_o,
  output mips_pkg::addr_t          ram_addr_o,
  output mips_pkg::data_t          ram_write_data_o,
  input  wire mips_pkg::data_t     ram_read_data_i,
  output logic                     wb_en_o,
  output mips_pkg::reg_addr_t      wb_addr_o,
  output mips_pkg::data_t          wb_data_o,
  output mips_pkg::addr_t          wb_pc_o,
  bypass_if.source                 mem_bypass
);
  import mips_pkg::*;

  // RAM request straight from EX/MEM
  assign ram_en_o         = exmem_i.valid && (exmem_i.mem_read || exmem_i.mem_write);
  assign ram_write_en_o   = exmem_i.valid && exmem_i.mem_write;
  assign ram_addr_o       = addr_t'(exmem_i.result);
  assign ram_write_data_o = exmem_i.store_data;

  // Load data not forwarded from here, decode holds instead
  assign mem_bypass.reg_write = exmem_i.valid && exmem_i.reg_write;
  assign mem_bypass.dest      = exmem_i.dest;
  assign mem_bypass.value     = exmem_i.result;
  assign mem_bypass.is_load   = exmem_i.mem_read;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb_en_o <= 1'b0;
    end else if (!stall_i) begin
      wb_en_o <= exmem_i.valid && exmem_i.reg_write;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i) begin
      wb_addr_o <= exmem_i.dest;
      wb_data_o <= exmem_i.mem_read ? ram_read_data_i : exmem_i.result;
      wb_pc_o   <= exmem_i.pc;
    end
  end

endmodule

`default_nettype wire

/* source/mips_pkg.sv */
`default_nettype none

`include "core_macros.svh"

package mips_pkg;

  typedef logic [`DATA_W-1:0]     data_t;
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [`ADDR_W-1:0]     addr_t;

  typedef struct packed {
    logic [`OPCODE_W-1:0] opcode;
    reg_addr_t            rs;
    reg_addr_t            rt;
    reg_addr_t            rd;
    logic [`SHAMT_W-1:0]  shamt;
    logic [`FUNCT_W-1:0]  funct;
  } r_fmt_t;

  typedef struct packed {
    logic [`OPCODE_W-1:0] opcode;
    reg_addr_t            rs;
    reg_addr_t            rt;
    logic [`IMM_W-1:0]    imm16;
  } i_fmt_t;

  // Same instruction word, R-format or I-format view
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } inst_u;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT,
    ALU_SLL
  } alu_op_e;

  typedef struct packed {
    logic                valid;
    alu_op_e             alu_op;
    data_t               operand_a;
    data_t               operand_b;
    logic [`SHAMT_W-1:0] shamt;
    logic                mem_read;
    logic                mem_write;
    data_t               store_data;
    logic                reg_write;
    reg_addr_t           dest;
    addr_t               pc;
  } idex_t;

  typedef struct packed {
    logic      valid;
    data_t     result;
    logic      mem_read;
    logic      mem_write;
    data_t     store_data;
    logic      reg_write;
    reg_addr_t dest;
    addr_t     pc;
  } exmem_t;

endpackage

`default_nettype wire

/* source/reg_file.sv */
`default_nettype none

`include "core_macros.svh"

module reg_file (
  input  wire logic                clk,
  input  wire logic                arst_n_i,
  input  wire mips_pkg::reg_addr_t rs_addr_i,
  input  wire mips_pkg::reg_addr_t rt_addr_i,
  output mips_pkg::data_t          rs_data_o,
  output mips_pkg::data_t          rt_data_o,
  input  wire logic                write_en_i,
  input  wire mips_pkg::reg_addr_t write_addr_i,
  input  wire mips_pkg::data_t     write_data_i
);
  import mips_pkg::*;

  data_t regs [`REG_COUNT];

  // Zero register, then write-through, then storage
  function automatic data_t read_port(input reg_addr_t addr);
    if (addr == '0) begin
      return '0;
    end else if (write_en_i && write_addr_i == addr) begin
      return write_data_i;
    end
    return regs[addr];
  endfunction

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en_i && write_addr_i != '0) begin
      regs[write_addr_i] <= write_data_i;
    end
  end

  always_comb begin
    rs_data_o = read_port(rs_addr_i);
    rt_data_o = read_port(rt_addr_i);
  end

endmodule

`default_nettype wire

/* tests/core_tb.sv */
`default_nettype none

`include "core_macros.svh"

module core_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import mips_pkg::*;

  localparam int MEM_WORDS    = 256;
  localparam int MAX_CYCLES   = 300;
  localparam int QUIET_CYCLES = 8;

  logic      clk;
  logic      arst_n;
  logic      stall;
  addr_t     rom_addr;
  data_t     rom_data;
  logic      ram_en;
  logic      ram_write_en;
  addr_t     ram_addr;
  data_t     ram_write_data;
  data_t     ram_read_data;
  logic      wb_en;
  reg_addr_t wb_addr;
  data_t     wb_data;
  addr_t     wb_pc;

  data_t rom [MEM_WORDS];
  data_t ram [MEM_WORDS];

  int          prog_len;
  int          errors;
  int          errors_before;
  int          tests_run;
  int          tests_failed;
  int          stall_left;
  int          stall_cycles;
  int unsigned lcg_state = 46;

  reg_addr_t exp_addr [$];
  data_t     exp_data [$];
  addr_t     exp_pc [$];
  reg_addr_t got_addr [$];
  data_t     got_data [$];
  addr_t     got_pc [$];

  core core_inst (
    .clk                    (clk),
    .arst_n_i               (arst_n),
    .stall_i                (stall),
    .rom_addr_o             (rom_addr),
    .rom_data_i             (rom_data),
    .ram_en_o               (ram_en),
    .ram_write_en_o         (ram_write_en),
    .ram_addr_o             (ram_addr),
    .ram_write_data_o       (ram_write_data),
    .ram_read_data_i        (ram_read_data),
    .debug_reg_write_en_o   (wb_en),
    .debug_reg_write_addr_o (wb_addr),
    .debug_reg_write_data_o (wb_data),
    .debug_pc_o             (wb_pc)
  );

  // Fetches past the ROM read as nops
  assign rom_data      = (rom_addr < addr_t'(MEM_WORDS * 4)) ? rom[rom_addr[9:2]] : '0;
  assign ram_read_data = ram_en ? ram[ram_addr[9:2]] : '0;

  function automatic data_t fill_word(input addr_t a);
    return ~a ^ {a[7:0], a[31:8]};
  endfunction

  // RAM gets its fill pattern back while reset is low
  always @(posedge clk) begin
    if (!arst_n) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        ram[i[7:0]] <= fill_word(addr_t'(i * 4));
      end
    end else if (ram_en && ram_write_en) begin
      ram[ram_addr[9:2]] <= ram_write_data;
    end
  end

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  function automatic logic stall_wanted();
    if (stall_left > 0) begin
      stall_left--;
      return 1'b1;
    end
    if (lcg_next() % 4 == 0) begin
      stall_left = int'(lcg_next() % 4);
      return 1'b1;
    end
    return 1'b0;
  endfunction

  function automatic data_t encode_r(input logic [`FUNCT_W-1:0] funct, input reg_addr_t rs,
                                     input reg_addr_t rt, input reg_addr_t rd,
                                     input logic [`SHAMT_W-1:0] shamt);
    return {`OP_SPECIAL, rs, rt, rd, shamt, funct};
  endfunction

  function automatic data_t encode_i(input logic [`OPCODE_W-1:0] op, input reg_addr_t rs,
                                     input reg_addr_t rt, input logic [`IMM_W-1:0] imm);
    return {op, rs, rt, imm};
  endfunction

  task automatic emit(input data_t word);
    rom[prog_len[7:0]] = word;
    prog_len++;
  endtask

  // Write-back expected from the instruction emitted last
  task automatic expect_wb(input reg_addr_t addr, input data_t value);
    exp_addr.push_back(addr);
    exp_data.push_back(value);
    exp_pc.push_back(addr_t'(4 * (prog_len - 1)));
  endtask

  task automatic check_data(input string what, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_reg_addr(input string what, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is r%0d, expected r%0d", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_addr(input string what, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic start_test();
    for (int i = 0; i < MEM_WORDS; i++) begin
      rom[i[7:0]] = '0;
    end
    prog_len = 0;
    exp_addr.delete();
    exp_data.delete();
    exp_pc.delete();
    errors_before = errors;
    tests_run++;
  endtask

  task automatic end_test(input string name);
    if (errors == errors_before) begin
      $display("Test %s passed", name);
    end else begin
      tests_failed++;
      $display("Test %s failed with %0d errors", name, errors - errors_before);
    end
  endtask

  task automatic reset_dut();
    @(posedge clk);
    arst_n <= 1'b0;
    stall  <= 1'b0;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
  endtask

  // Values are sampled mid-cycle, where they hold for the next rising edge
  task automatic run_program(input logic with_stall);
    int cycles;
    int extra;
    cycles       = 0;
    extra        = 0;
    stall_cycles = 0;
    stall_left   = 0;
    got_addr.delete();
    got_data.delete();
    got_pc.delete();
    while (got_data.size() < exp_data.size() && cycles < MAX_CYCLES) begin
      @(posedge clk);
      stall <= with_stall && stall_wanted();
      @(negedge clk);
      cycles++;
      if (stall) begin
        stall_cycles++;
      end else if (wb_en) begin
        got_addr.push_back(wb_addr);
        got_data.push_back(wb_data);
        got_pc.push_back(wb_pc);
      end
    end
    @(posedge clk);
    stall <= 1'b0;
    if (got_data.size() < exp_data.size()) begin
      $display("Timed out after %0d cycles with only %0d of %0d write-backs seen",
               cycles, got_data.size(), exp_data.size());
      errors++;
    end
    for (int i = 0; i < QUIET_CYCLES; i++) begin
      @(negedge clk);
      if (wb_en) begin
        extra++;
      end
      @(posedge clk);
    end
    if (extra > 0) begin
      $display("Error at %0t ns: %0d write-backs beyond the expected ones", $time, extra);
      errors++;
    end
    for (int i = 0; i < got_data.size(); i++) begin
      check_reg_addr($sformatf("write-back %0d register", i), got_addr[i], exp_addr[i]);
      check_data($sformatf("write-back %0d data", i), got_data[i], exp_data[i]);
      check_addr($sformatf("write-back %0d pc", i), got_pc[i], exp_pc[i]);
    end
  endtask

  // Dependent ALU ops back to back, forwarded from EX and MEM
  task automatic load_alu_program();
    emit(encode_i(`OP_ADDIU, 5'd0, 5'd1, 16'd5));
    expect_wb(5'd1, 32'd5);
    emit(encode_i(`OP_ADDIU, 5'd1, 5'd2, 16'hFFFD));
    expect_wb(5'd2, 32'd2);
    emit(encode_i(`OP_ORI, 5'd1, 5'd3, 16'hF0F0));
    expect_wb(5'd3, 32'h0000_F0F5);
    emit(encode_i(`OP_LUI, 5'd0, 5'd4, 16'h8001));
    expect_wb(5'd4, 32'h8001_0000);
    emit(encode_r(`FN_ADDU, 5'd4, 5'd3, 5'd5, 5'd0));
    expect_wb(5'd5, 32'h8001_F0F5);
    emit(encode_r(`FN_SUBU, 5'd2, 5'd1, 5'd6, 5'd0));
    expect_wb(5'd6, 32'hFFFF_FFFD);
    emit(encode_r(`FN_AND, 5'd5, 5'd3, 5'd7, 5'd0));
    expect_wb(5'd7, 32'h0000_F0F5);
    emit(encode_r(`FN_OR, 5'd2, 5'd4, 5'd8, 5'd0));
    expect_wb(5'd8, 32'h8001_0002);
    // -3 < 5 signed, and the reverse
    emit(encode_r(`FN_SLT, 5'd6, 5'd1, 5'd9, 5'd0));
    expect_wb(5'd9, 32'd1);
    emit(encode_r(`FN_SLT, 5'd1, 5'd6, 5'd10, 5'd0));
    expect_wb(5'd10, 32'd0);
    emit(encode_r(`FN_SLL, 5'd0, 5'd9, 5'd11, 5'd4));
    expect_wb(5'd11, 32'd16);
    emit(encode_r(`FN_ADDU, 5'd11, 5'd8, 5'd12, 5'd0));
    expect_wb(5'd12, 32'h8001_0012);
  endtask

  task automatic alu_chain_test();
    start_test();
    load_alu_program();
    reset_dut();
    run_program(1'b0);
    end_test("alu_chain");
  endtask

  task automatic memory_test();
    start_test();
    emit(encode_i(`OP_ADDIU, 5'd0, 5'd1, 16'h0040));
    expect_wb(5'd1, 32'h40);
    emit(encode_i(`OP_LUI, 5'd0, 5'd2, 16'h1234));
    expect_wb(5'd2, 32'h1234_0000);
    emit(encode_i(`OP_ORI, 5'd2, 5'd2, 16'h5678));
    expect_wb(5'd2, 32'h1234_5678);
    emit(encode_i(`OP_SW, 5'd1, 5'd2, 16'd8));
    emit(encode_i(`OP_LW, 5'd1, 5'd3, 16'd8));
    expect_wb(5'd3, 32'h1234_5678);
    // Load result used right away
    emit(encode_r(`FN_ADDU, 5'd3, 5'd1, 5'd4, 5'd0));
    expect_wb(5'd4, 32'h1234_56B8);
    emit(encode_i(`OP_LW, 5'd1, 5'd5, 16'd12));
    expect_wb(5'd5, fill_word(32'h4C));
    emit(encode_i(`OP_ADDIU, 5'd0, 5'd6, 16'd7));
    expect_wb(5'd6, 32'd7);
    emit(encode_r(`FN_ADDU, 5'd5, 5'd6, 5'd7, 5'd0));
    expect_wb(5'd7, fill_word(32'h4C) + 32'd7);
    reset_dut();
    run_program(1'b0);
    // Byte address 0x48
    check_data("RAM word at 0x48", ram[8'd18], 32'h1234_5678);
    end_test("memory");
  endtask

  task automatic branch_test();
    start_test();
    emit(encode_i(`OP_ADDIU, 5'd0, 5'd1, 16'd3));
    expect_wb(5'd1, 32'd3);
    emit(encode_i(`OP_ADDIU, 5'd0, 5'd2, 16'd3));
    expect_wb(5'd2, 32'd3);
    emit(encode_i(`OP_BEQ, 5'd1, 5'd2, 16'd2));
    emit(encode_i(`OP_ADDIU, 5'd0, 5'd3, 16'h11));
    expect_wb(5'd3, 32'h11);
    // Skipped by the taken BEQ
    emit(encode_i(`OP_ADDIU, 5'd0, 5'd4, 16'h22));
    emit(encode_i(`OP_BNE, 5'd1, 5'd0, 16'd2));
    emit(encode_i(`OP_ADDIU, 5'd0, 5'd5, 16'h33));
    expect_wb(5'd5, 32'h33);
    emit(encode_i(`OP_ADDIU, 5'd0, 5'd6, 16'h44));
    // Neither of these is taken
    emit(encode_i(`OP_BEQ, 5'd1, 5'd0, 16'd2));
    emit(encode_i(`OP_ADDIU, 5'd0, 5'd7, 16'h55));
    expect_wb(5'd7, 32'h55);
    emit(encode_i(`OP_BNE, 5'd1, 5'd2, 16'd5));
    emit(encode_i(`OP_ADDIU, 5'd0, 5'd8, 16'h66));
    expect_wb(5'd8, 32'h66);
    emit(encode_i(`OP_ADDIU, 5'd1, 5'd9, 16'h10));
    expect_wb(5'd9, 32'h13);
    reset_dut();
    run_program(1'b0);
    end_test("branches");
  endtask

  task automatic zero_reg_test();
    start_test();
    emit(encode_i(`OP_ADDIU, 5'd0, 5'd0, 16'h77));
    emit(encode_i(`OP_ADDIU, 5'd0, 5'd1, 16'h25));
    expect_wb(5'd1, 32'h25);
    emit(encode_i(`OP_ORI, 5'd1, 5'd0, 16'hFF));
    emit(encode_r(`FN_ADDU, 5'd0, 5'd1, 5'd2, 5'd0));
    expect_wb(5'd2, 32'h25);
    emit(encode_r(`FN_ADDU, 5'd1, 5'd0, 5'd3, 5'd0));
    expect_wb(5'd3, 32'h25);
    emit(encode_i(`OP_ADDIU, 5'd0, 5'd4, 16'd1));
    expect_wb(5'd4, 32'd1);
    reset_dut();
    run_program(1'b0);
    end_test("register_zero");
  endtask

  task automatic stall_test();
    start_test();
    load_alu_program();
    reset_dut();
    run_program(1'b1);
    if (stall_cycles == 0) begin
      $display("The stall input was never raised during the stall test");
      errors++;
    end
    end_test("external_stall");
  endtask

  initial begin
    arst_n       = 1'b0;
    stall        = 1'b0;
    prog_len     = 0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    stall_left   = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      rom[i[7:0]] = '0;
    end
    alu_chain_test();
    memory_test();
    branch_test();
    zero_reg_test();
    stall_test();
    $display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
